// File: include/i2c_slave_settings.svh
`ifndef I2C_SLAVE_SETTINGS_SVH
`define I2C_SLAVE_SETTINGS_SVH

// 7-bit address answered on the I2C bus
`define I2C_SLAVE_ADDR 7'h50

// Byte address width of the shared memory
// 7 bits gives 128 bytes, or 32 words
`define MEM_ADDR_BITS 7

// Flops in the SCL/SDA synchroniser chain
`define SYNC_STAGES 2

// Delay from an I2C write strobe to the pointer step
// Lets the byte land in memory before the next prefetch
`define WR_SETTLE_CYCLES 3

`endif

// File: rtl/i2c_slave_pkg.sv
`include "i2c_slave_settings.svh"

package i2c_slave_pkg;

	// Data and address vectors
	typedef logic [7:0] byte_t;
	typedef logic [`MEM_ADDR_BITS-1:0] byte_addr_t;
	typedef logic [`MEM_ADDR_BITS-3:0] word_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0] byte_sel_t;

	// Bit-level protocol FSM
	typedef enum logic [2:0]
	{
		I2C_IDLE,
		I2C_START,
		I2C_ADDR,
		I2C_SACK,
		I2C_RX,
		I2C_MACK,
		I2C_TX,
		I2C_IGNORE
	} i2c_state_e;

	// Byte pointer FSM
	typedef enum logic [1:0] {PTR_IDLE, PTR_WRITE, PTR_SEND} ptr_state_e;

endpackage

// File: rtl/i2c_line_monitor.sv
`timescale 1ns/10ps
`include "i2c_slave_settings.svh"

module i2c_line_monitor
(
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda,
	output logic o_scl_rise,
	output logic o_scl_fall,
	output logic o_start,
	output logic o_stop
);

	logic [`SYNC_STAGES-1:0] scl_pipe;
	logic [`SYNC_STAGES-1:0] sda_pipe;
	logic scl_last;
	logic sda_last;
	logic scl_now;
	logic sda_now;

	// Oldest stage is the settled level
	assign scl_now = scl_pipe[`SYNC_STAGES-1];
	assign sda_now = sda_pipe[`SYNC_STAGES-1];

	// Synchroniser plus one cycle of history
	// Released bus reads as high, so reset to ones
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			scl_pipe <= '1;
			sda_pipe <= '1;
			scl_last <= 1'b1;
			sda_last <= 1'b1;
		end
		else
		begin
			scl_pipe <= {scl_pipe[`SYNC_STAGES-2:0], i_scl};
			sda_pipe <= {sda_pipe[`SYNC_STAGES-2:0], i_sda};
			scl_last <= scl_now;
			sda_last <= sda_now;
		end
	end

	assign o_sda = sda_now;

	// Clock edges
	assign o_scl_rise = scl_now && !scl_last;
	assign o_scl_fall = !scl_now && scl_last;

	// SDA moving while SCL held high
	assign o_start = scl_now && scl_last && sda_last && !sda_now;
	assign o_stop  = scl_now && scl_last && !sda_last && sda_now;

endmodule

// File: rtl/i2c_slave_engine.sv
`timescale 1ns/10ps
`include "i2c_slave_settings.svh"

module i2c_slave_engine
	import i2c_slave_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_reset,
	input  logic  i_sda,
	input  logic  i_scl_rise,
	input  logic  i_scl_fall,
	input  logic  i_start,
	input  logic  i_stop,
	input  byte_t i_tx_byte,
	output logic  o_scl,
	output logic  o_sda,
	output logic  o_rx_stb,
	output byte_t o_rx_byte,
	output logic  o_tx_stb,
	output logic  o_bus_idle
);

	i2c_state_e state;
	byte_t      shift_in;
	byte_t      shift_out;
	logic [2:0] bit_cnt;
	logic       read_xfer;
	logic       byte_done;

	// Eighth falling edge closes a byte
	assign byte_done = i_scl_fall && (bit_cnt == 3'd7);

	// No clock stretching, SCL stays released
	assign o_scl = 1'b1;

	// Pointer resets while nothing is addressed to us
	assign o_bus_idle = (state == I2C_IDLE) || (state == I2C_START)
		|| (state == I2C_IGNORE);

	////////////////////////////////////////
	// Shift registers
	////////////////////////////////////////

	// Master data sampled on SCL rise
	always_ff @(posedge i_clk)
	begin
		if (i_scl_rise)
			shift_in <= {shift_in[6:0], i_sda};
	end

	// Next byte loaded as an ACK slot ends
	// Otherwise shifted MSB first on SCL fall
	always_ff @(posedge i_clk)
	begin
		if (i_scl_fall)
		begin
			if ((state == I2C_SACK) || (state == I2C_MACK))
				shift_out <= i_tx_byte;
			else
				shift_out <= {shift_out[6:0], 1'b1};
		end
	end

	// Completed receive byte
	always_ff @(posedge i_clk)
	begin
		if (byte_done && (state == I2C_RX))
			o_rx_byte <= shift_in;
	end

	////////////////////////////////////////
	// Protocol FSM
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state     <= I2C_IDLE;
			bit_cnt   <= 3'd0;
			read_xfer <= 1'b0;
			o_sda     <= 1'b1;
			o_rx_stb  <= 1'b0;
			o_tx_stb  <= 1'b0;
		end
		else
		begin
			// SDA released unless a state pulls it
			o_sda    <= 1'b1;
			o_rx_stb <= 1'b0;
			o_tx_stb <= 1'b0;
			if (i_scl_fall)
				bit_cnt <= bit_cnt + 3'd1;

			case (state)
			I2C_IDLE:
				bit_cnt <= 3'd0;
			I2C_START:
			begin
				// First SCL fall after START opens the address
				bit_cnt <= 3'd0;
				if (i_scl_fall)
					state <= I2C_ADDR;
			end
			I2C_ADDR:
			begin
				if (byte_done)
				begin
					// LSB is the R/W bit
					read_xfer <= shift_in[0];
					if (shift_in[7:1] == `I2C_SLAVE_ADDR)
						state <= I2C_SACK;
					else
						state <= I2C_IGNORE;
				end
			end
			I2C_SACK:
			begin
				// Pull SDA low through the ACK bit
				bit_cnt <= 3'd0;
				o_sda   <= 1'b0;
				if (i_scl_fall)
					state <= read_xfer ? I2C_TX : I2C_RX;
			end
			I2C_RX:
			begin
				if (byte_done)
				begin
					o_rx_stb <= 1'b1;
					state    <= I2C_SACK;
				end
			end
			I2C_TX:
			begin
				o_sda <= shift_out[7];
				if (byte_done)
				begin
					o_tx_stb <= 1'b1;
					state    <= I2C_MACK;
				end
			end
			I2C_MACK:
			begin
				// Master ACK bit sampled on the last rise
				// NACK ends the read
				bit_cnt <= 3'd0;
				if (i_scl_fall)
					state <= shift_in[0] ? I2C_IDLE : I2C_TX;
			end
			I2C_IGNORE:
				bit_cnt <= 3'd0;
			default:
				state <= I2C_IDLE;
			endcase

			// Bus conditions win over every state
			if (i_stop)
				state <= I2C_IDLE;
			else if (i_start)
				state <= I2C_START;
		end
	end

endmodule

// File: rtl/i2c_byte_pointer.sv
`timescale 1ns/10ps
`include "i2c_slave_settings.svh"

module i2c_byte_pointer
	import i2c_slave_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_rx_stb,
	input  byte_t      i_rx_byte,
	input  logic       i_tx_stb,
	input  logic       i_bus_idle,
	input  word_t      i_rd_word,
	output byte_t      o_tx_byte,
	output logic       o_wr_stb,
	output byte_addr_t o_wr_addr,
	output byte_t      o_wr_byte,
	output logic       o_rd_stb,
	output byte_addr_t o_rd_addr
);

	ptr_state_e state;
	byte_addr_t ptr;
	logic [`WR_SETTLE_CYCLES-1:0] settle;
	logic       rd_pend;
	logic [1:0] rd_lane;
	logic       advance;

	// Both memory requests use the live pointer
	assign o_wr_addr = ptr;
	assign o_rd_addr = ptr;

	// Write has settled, step to the next byte
	assign advance = settle[`WR_SETTLE_CYCLES-1];

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state    <= PTR_IDLE;
			ptr      <= '0;
			settle   <= '0;
			rd_pend  <= 1'b0;
			o_wr_stb <= 1'b0;
			o_rd_stb <= 1'b0;
		end
		else
		begin
			o_wr_stb <= 1'b0;
			o_rd_stb <= 1'b0;
			settle   <= {settle[`WR_SETTLE_CYCLES-2:0], o_wr_stb};
			rd_pend  <= o_rd_stb;

			case (state)
			PTR_IDLE:
			begin
				if (i_rx_stb)
				begin
					// First write byte is the pointer itself
					ptr      <= i_rx_byte[`MEM_ADDR_BITS-1:0];
					o_rd_stb <= 1'b1;
					state    <= PTR_WRITE;
				end
				else if (i_tx_stb)
				begin
					ptr      <= ptr + 1'b1;
					o_rd_stb <= 1'b1;
					state    <= PTR_SEND;
				end
			end
			PTR_WRITE:
			begin
				if (i_rx_stb)
					o_wr_stb <= 1'b1;
			end
			PTR_SEND:
			begin
				// Prefetch for the following byte
				if (i_tx_stb)
				begin
					ptr      <= ptr + 1'b1;
					o_rd_stb <= 1'b1;
				end
			end
			default:
				state <= PTR_IDLE;
			endcase

			if (advance)
			begin
				ptr      <= ptr + 1'b1;
				o_rd_stb <= 1'b1;
			end

			if (i_bus_idle)
				state <= PTR_IDLE;
		end
	end

	// Data byte for the pending write
	always_ff @(posedge i_clk)
	begin
		if ((state == PTR_WRITE) && i_rx_stb)
			o_wr_byte <= i_rx_byte;
	end

	// Lane remembered from the read strobe
	// Word arrives a cycle later, lane 0 in the top bits
	always_ff @(posedge i_clk)
	begin
		if (o_rd_stb)
			rd_lane <= ptr[1:0];
		if (rd_pend)
		begin
			case (rd_lane)
			2'd0: o_tx_byte <= i_rd_word[31:24];
			2'd1: o_tx_byte <= i_rd_word[23:16];
			2'd2: o_tx_byte <= i_rd_word[15:8];
			default: o_tx_byte <= i_rd_word[7:0];
			endcase
		end
	end

endmodule

// File: rtl/shared_byte_memory.sv
`timescale 1ns/10ps
`include "i2c_slave_settings.svh"

module shared_byte_memory
	import i2c_slave_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_i2c_wr_stb,
	input  byte_addr_t i_i2c_wr_addr,
	input  byte_t      i_i2c_wr_byte,
	input  logic       i_i2c_rd_stb,
	input  byte_addr_t i_i2c_rd_addr,
	output word_t      o_i2c_rd_word,
	input  logic       i_wb_stb,
	input  logic       i_wb_we,
	input  word_addr_t i_wb_addr,
	input  word_t      i_wb_data,
	input  byte_sel_t  i_wb_sel,
	output logic       o_wb_stall,
	output logic       o_wb_ack,
	output word_t      o_wb_data,
	input  logic       i_s_valid,
	input  byte_t      i_s_data,
	input  logic       i_s_last,
	output logic       o_s_ready
);

	word_t      mem [0:(1 << (`MEM_ADDR_BITS - 2)) - 1];
	byte_sel_t  wr_en;
	word_addr_t wr_addr;
	word_t      wr_data;
	byte_addr_t s_addr;
	logic       s_take;
	logic       wb_take;

	// Lane enable for a byte address, byte 0 in bits 31:24
	function automatic byte_sel_t lane_of(input logic [1:0] lsb);
		lane_of = 4'b1000 >> lsb;
	endfunction

	// I2C write claims the write register this cycle
	assign o_s_ready  = !i_i2c_wr_stb;
	assign o_wb_stall = i_i2c_wr_stb || i_s_valid;

	assign s_take  = i_s_valid && o_s_ready;
	assign wb_take = i_wb_stb && i_wb_we && !o_wb_stall;

	////////////////////////////////////////
	// Write register and array
	////////////////////////////////////////

	// Priority: I2C, then stream, then bus
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wr_en <= '0;
		else if (i_i2c_wr_stb)
		begin
			wr_en   <= lane_of(i_i2c_wr_addr[1:0]);
			wr_addr <= i_i2c_wr_addr[`MEM_ADDR_BITS-1:2];
			wr_data <= {4{i_i2c_wr_byte}};
		end
		else if (s_take)
		begin
			wr_en   <= lane_of(s_addr[1:0]);
			wr_addr <= s_addr[`MEM_ADDR_BITS-1:2];
			wr_data <= {4{i_s_data}};
		end
		else if (wb_take)
		begin
			wr_en   <= i_wb_sel;
			wr_addr <= i_wb_addr;
			wr_data <= i_wb_data;
		end
		else
			wr_en <= '0;
	end

	// Per-lane byte write
	always_ff @(posedge i_clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (wr_en[i])
				mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
		end
	end

	// Stream byte address, back to zero after last
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			s_addr <= '0;
		else if (s_take)
			s_addr <= i_s_last ? '0 : s_addr + 1'b1;
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Bus data lines up with the ack
	always_ff @(posedge i_clk)
	begin
		o_wb_data <= mem[i_wb_addr];
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= i_wb_stb && !o_wb_stall;
	end

	// Word for the pointer's prefetch
	always_ff @(posedge i_clk)
	begin
		if (i_i2c_rd_stb)
			o_i2c_rd_word <= mem[i_i2c_rd_addr[`MEM_ADDR_BITS-1:2]];
	end

endmodule

// File: rtl/wb_i2c_slave.sv
`timescale 1ns/10ps

module wb_i2c_slave
	import i2c_slave_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	// Wishbone pipelined slave
	input  logic       i_wb_stb,
	input  logic       i_wb_we,
	input  word_addr_t i_wb_addr,
	input  word_t      i_wb_data,
	input  byte_sel_t  i_wb_sel,
	output logic       o_wb_stall,
	output logic       o_wb_ack,
	output word_t      o_wb_data,
	// Byte stream fill
	input  logic       i_s_valid,
	input  byte_t      i_s_data,
	input  logic       i_s_last,
	output logic       o_s_ready,
	// Open-drain pins, 1 releases the line
	input  logic       i_i2c_scl,
	input  logic       i_i2c_sda,
	output logic       o_i2c_scl,
	output logic       o_i2c_sda
);

	// Line monitor to engine
	logic sda_level;
	logic scl_rise;
	logic scl_fall;
	logic bus_start;
	logic bus_stop;

	// Engine to pointer
	logic  rx_stb;
	byte_t rx_byte;
	logic  tx_stb;
	byte_t tx_byte;
	logic  bus_idle;

	// Pointer to memory
	logic       wr_stb;
	byte_addr_t wr_addr;
	byte_t      wr_byte;
	logic       rd_stb;
	byte_addr_t rd_addr;
	word_t      rd_word;

	i2c_line_monitor line_monitor_inst
	(
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_scl      (i_i2c_scl),
		.i_sda      (i_i2c_sda),
		.o_sda      (sda_level),
		.o_scl_rise (scl_rise),
		.o_scl_fall (scl_fall),
		.o_start    (bus_start),
		.o_stop     (bus_stop)
	);

	i2c_slave_engine slave_engine_inst
	(
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_sda      (sda_level),
		.i_scl_rise (scl_rise),
		.i_scl_fall (scl_fall),
		.i_start    (bus_start),
		.i_stop     (bus_stop),
		.i_tx_byte  (tx_byte),
		.o_scl      (o_i2c_scl),
		.o_sda      (o_i2c_sda),
		.o_rx_stb   (rx_stb),
		.o_rx_byte  (rx_byte),
		.o_tx_stb   (tx_stb),
		.o_bus_idle (bus_idle)
	);

	i2c_byte_pointer byte_pointer_inst
	(
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_rx_stb   (rx_stb),
		.i_rx_byte  (rx_byte),
		.i_tx_stb   (tx_stb),
		.i_bus_idle (bus_idle),
		.i_rd_word  (rd_word),
		.o_tx_byte  (tx_byte),
		.o_wr_stb   (wr_stb),
		.o_wr_addr  (wr_addr),
		.o_wr_byte  (wr_byte),
		.o_rd_stb   (rd_stb),
		.o_rd_addr  (rd_addr)
	);

	shared_byte_memory byte_memory_inst
	(
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_i2c_wr_stb  (wr_stb),
		.i_i2c_wr_addr (wr_addr),
		.i_i2c_wr_byte (wr_byte),
		.i_i2c_rd_stb  (rd_stb),
		.i_i2c_rd_addr (rd_addr),
		.o_i2c_rd_word (rd_word),
		.i_wb_stb      (i_wb_stb),
		.i_wb_we       (i_wb_we),
		.i_wb_addr     (i_wb_addr),
		.i_wb_data     (i_wb_data),
		.i_wb_sel      (i_wb_sel),
		.o_wb_stall    (o_wb_stall),
		.o_wb_ack      (o_wb_ack),
		.o_wb_data     (o_wb_data),
		.i_s_valid     (i_s_valid),
		.i_s_data      (i_s_data),
		.i_s_last      (i_s_last),
		.o_s_ready     (o_s_ready)
	);

endmodule

// File: verif/wb_i2c_slave_tb.sv
`timescale 1ns/10ps
`include "i2c_slave_settings.svh"

module wb_i2c_slave_tb
	import i2c_slave_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	// SCL phase length in clocks
	// SDA moves HALF clocks into a low phase
	localparam int PHASE = 25;
	localparam int HALF = 12;
	localparam int NUM_TESTS = 6;
	localparam int MEM_BYTES = 1 << `MEM_ADDR_BITS;
	localparam int MEM_WORDS = MEM_BYTES / 4;
	// 40 bit periods per test
	localparam int WATCHDOG_NS = NUM_TESTS * 40 * 2 * PHASE * CLK_PERIOD;
	localparam int STALL_LIMIT = 200;

	logic       clk;
	logic       reset;
	logic       wb_stb;
	logic       wb_we;
	word_addr_t wb_addr;
	word_t      wb_data;
	byte_sel_t  wb_sel;
	logic       wb_stall;
	logic       wb_ack;
	word_t      wb_rdata;
	logic       s_valid;
	byte_t      s_data;
	logic       s_last;
	logic       s_ready;
	logic       m_scl;
	logic       m_sda;
	logic       dut_scl;
	logic       dut_sda;
	logic       scl_line;
	logic       sda_line;

	// Reference memory with byte 0 of a word in bits 31:24
	byte_t ref_mem [0:MEM_BYTES-1];
	int    stream_addr;
	int    errors;
	int    errors_at_start;
	int    tests_passed;
	int    tests_failed;

	// Open-drain bus as a wired-AND of both sides
	assign scl_line = m_scl & dut_scl;
	assign sda_line = m_sda & dut_sda;

	wb_i2c_slave wb_i2c_slave_inst
	(
		.i_clk      (clk),
		.i_reset    (reset),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_addr  (wb_addr),
		.i_wb_data  (wb_data),
		.i_wb_sel   (wb_sel),
		.o_wb_stall (wb_stall),
		.o_wb_ack   (wb_ack),
		.o_wb_data  (wb_rdata),
		.i_s_valid  (s_valid),
		.i_s_data   (s_data),
		.i_s_last   (s_last),
		.o_s_ready  (s_ready),
		.i_i2c_scl  (scl_line),
		.i_i2c_sda  (sda_line),
		.o_i2c_scl  (dut_scl),
		.o_i2c_sda  (dut_sda)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////

	task automatic wait_clocks(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic word_t ref_word(input word_addr_t addr);
		int base;
		base = int'(addr) * 4;
		ref_word = {ref_mem[base], ref_mem[base + 1], ref_mem[base + 2], ref_mem[base + 3]};
	endfunction

	task automatic report_test(input string name);
		if (errors == errors_at_start)
		begin
			tests_passed++;
			$display("Test %-22s passed", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %-22s failed with %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	////////////////////////////////////////
	// Bus and stream drivers
	////////////////////////////////////////

	// One request held until not stalled
	// Ack expected the cycle after acceptance
	task automatic bus_access(input logic we, input word_addr_t addr, input word_t data,
		input byte_sel_t sel, output word_t rdata, output time accept_time);
		int   waited;
		logic stalled;
		waited = 0;
		stalled = 1'b1;
		accept_time = 0;
		@(negedge clk);
		wb_stb = 1'b1;
		wb_we = we;
		wb_addr = addr;
		wb_data = data;
		wb_sel = sel;
		while (stalled && (waited < STALL_LIMIT))
		begin
			// Stall settles well before the edge
			#1;
			stalled = wb_stall;
			@(posedge clk);
			accept_time = $time;
			@(negedge clk);
			compare($sformatf("ack for word %0d", addr), 32'(wb_ack), 32'(!stalled));
			waited++;
		end
		rdata = wb_rdata;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (stalled)
		begin
			$display("Bus request to word %0d was never accepted", addr);
			errors++;
		end
	endtask

	task automatic bus_write(input word_addr_t addr, input word_t data, input byte_sel_t sel,
		output time accept_time);
		word_t unused;
		bus_access(1'b1, addr, data, sel, unused, accept_time);
		// Select bit 3 covers the lowest byte address
		for (int k = 0; k < 4; k++)
		begin
			if (sel[3 - k])
				ref_mem[int'(addr) * 4 + k] = data[31 - 8 * k -: 8];
		end
	endtask

	task automatic check_word(input word_addr_t addr);
		word_t got;
		time   t;
		bus_access(1'b0, addr, '0, '0, got, t);
		compare($sformatf("word %0d", addr), got, ref_word(addr));
	endtask

	task automatic check_all_words();
		for (int w = 0; w < MEM_WORDS; w++)
			check_word(word_addr_t'(w));
	endtask

	// Back-to-back bytes with the address wrapping to 0 after last
	task automatic stream_packet(input int len, output time end_time);
		byte_t b;
		logic  taken;
		end_time = 0;
		for (int n = 0; n < len; n++)
		begin
			b = byte_t'($urandom);
			@(negedge clk);
			s_valid = 1'b1;
			s_data = b;
			s_last = (n == len - 1);
			taken = 1'b0;
			while (!taken)
			begin
				#1;
				taken = s_ready;
				// Ready stays high with no I2C write in flight
				compare($sformatf("stream ready for byte %0d", n), 32'(taken), 32'd1);
				@(posedge clk);
				if (!taken)
					@(negedge clk);
			end
			end_time = $time;
			ref_mem[stream_addr] = b;
			stream_addr = s_last ? 0 : (stream_addr + 1) % MEM_BYTES;
		end
		@(negedge clk);
		s_valid = 1'b0;
		s_last = 1'b0;
	endtask

	////////////////////////////////////////
	// I2C master model
	////////////////////////////////////////

	// SCL low on entry and exit
	task automatic clock_bit(input logic drive, output logic sampled);
		wait_clocks(HALF);
		m_sda = drive;
		wait_clocks(PHASE - HALF);
		m_scl = 1'b1;
		wait_clocks(HALF);
		sampled = sda_line;
		// Slave never stretches the clock
		compare("slave SCL output", 32'(dut_scl), 32'd1);
		wait_clocks(PHASE - HALF);
		m_scl = 1'b0;
	endtask

	// Works from idle and as a repeated START
	task automatic send_start();
		wait_clocks(HALF);
		m_sda = 1'b1;
		wait_clocks(PHASE - HALF);
		m_scl = 1'b1;
		wait_clocks(PHASE);
		m_sda = 1'b0;
		wait_clocks(PHASE);
		m_scl = 1'b0;
	endtask

	task automatic send_stop();
		wait_clocks(HALF);
		m_sda = 1'b0;
		wait_clocks(PHASE - HALF);
		m_scl = 1'b1;
		wait_clocks(PHASE);
		m_sda = 1'b1;
		wait_clocks(PHASE);
	endtask

	task automatic write_byte(input byte_t b, output logic acked);
		logic s;
		for (int n = 7; n >= 0; n--)
			clock_bit(b[n], s);
		// Slave pulls the released SDA low to ACK
		clock_bit(1'b1, s);
		acked = !s;
	endtask

	task automatic read_byte(input logic ack, output byte_t b);
		logic s;
		for (int n = 7; n >= 0; n--)
		begin
			clock_bit(1'b1, s);
			b[n] = s;
		end
		clock_bit(!ack, s);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_bus_access();
		word_addr_t a;
		time        t;
		for (int w = 0; w < MEM_WORDS; w++)
			bus_write(word_addr_t'(w), word_t'($urandom), 4'hf, t);
		for (int n = 0; n < 16; n++)
		begin
			a = word_addr_t'($urandom);
			bus_write(a, word_t'($urandom), byte_sel_t'($urandom), t);
			check_word(a);
		end
		check_all_words();
	endtask

	task automatic test_i2c_write();
		logic  acked;
		byte_t b;
		int    start_addr;
		// Runs past byte 127 into word 0
		start_addr = 126;
		send_start();
		write_byte({`I2C_SLAVE_ADDR, 1'b0}, acked);
		compare("address ack", 32'(acked), 32'd1);
		write_byte(byte_t'(start_addr), acked);
		compare("pointer ack", 32'(acked), 32'd1);
		for (int n = 0; n < 4; n++)
		begin
			b = byte_t'($urandom);
			write_byte(b, acked);
			compare($sformatf("data byte %0d ack", n), 32'(acked), 32'd1);
			ref_mem[(start_addr + n) % MEM_BYTES] = b;
		end
		send_stop();
		check_all_words();
	endtask

	task automatic test_i2c_read();
		logic  acked;
		byte_t b;
		int    start_addr;
		time   t;
		for (int w = 10; w < 13; w++)
			bus_write(word_addr_t'(w), word_t'($urandom), 4'hf, t);
		// Lane 2 of word 10
		start_addr = 42;
		send_start();
		write_byte({`I2C_SLAVE_ADDR, 1'b0}, acked);
		compare("address ack", 32'(acked), 32'd1);
		write_byte(byte_t'(start_addr), acked);
		compare("pointer ack", 32'(acked), 32'd1);
		send_start();
		write_byte({`I2C_SLAVE_ADDR, 1'b1}, acked);
		compare("read address ack", 32'(acked), 32'd1);
		// NACK on the last byte
		for (int n = 0; n < 5; n++)
		begin
			read_byte(n < 4, b);
			compare($sformatf("read byte %0d", n), 32'(b), 32'(ref_mem[start_addr + n]));
		end
		send_stop();
	endtask

	task automatic test_wrong_address();
		logic acked;
		send_start();
		write_byte({7'h23, 1'b0}, acked);
		compare("foreign address ack", 32'(acked), 32'd0);
		write_byte(8'h05, acked);
		compare("foreign data ack", 32'(acked), 32'd0);
		send_stop();
		check_all_words();
	endtask

	task automatic test_stream_fill();
		time t;
		// Second packet overwrites bytes 0 to 4
		stream_packet(7, t);
		stream_packet(5, t);
		check_all_words();
	endtask

	task automatic test_stream_and_bus();
		time stream_end;
		time bus_accept;
		fork
			stream_packet(6, stream_end);
			bus_write(word_addr_t'(8), word_t'($urandom), 4'hf, bus_accept);
		join
		assert (bus_accept > stream_end)
		else
		begin
			$display("Bus write was accepted at %0d ns while the stream ran until %0d ns",
				bus_accept, stream_end);
			errors++;
		end
		check_all_words();
	endtask

	initial
	begin
		void'($urandom(32'h563a));
		reset = 1'b1;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		wb_sel = '0;
		s_valid = 1'b0;
		s_data = '0;
		s_last = 1'b0;
		m_scl = 1'b1;
		m_sda = 1'b1;
		stream_addr = 0;
		errors = 0;
		errors_at_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		test_bus_access();
		report_test("bus access");
		test_i2c_write();
		report_test("i2c write");
		test_i2c_read();
		report_test("i2c read");
		test_wrong_address();
		report_test("wrong address");
		test_stream_fill();
		report_test("stream fill");
		test_stream_and_bus();
		report_test("stream and bus");

		$display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
rtl/i2c_slave_pkg.sv
rtl/i2c_line_monitor.sv
rtl/i2c_slave_engine.sv
rtl/i2c_byte_pointer.sv
rtl/shared_byte_memory.sv
rtl/wb_i2c_slave.sv
verif/wb_i2c_slave_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
		-f compile.f --top-module wb_i2c_slave_tb --Mdir obj_dir -o wb_i2c_slave_sim
	./obj_dir/wb_i2c_slave_sim > sim.log 2>&1; cat sim.log
	@grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
